// File: Bender.yml
package:
  name: surface_unit

sources:
  - files:
      - source/surfacePkg.sv
      - source/rayIntake.sv
      - source/primitiveScheduler.sv
      - source/closestHitTracker.sv
      - source/surfaceShade.sv
      - source/surfaceUnit.sv
  - target: test
    files:
      - testbench/surfaceUnit_chk.sv
      - testbench/surfaceUnitTb.sv

// File: project.f
source/surfacePkg.sv
source/rayIntake.sv
source/primitiveScheduler.sv
source/closestHitTracker.sv
source/surfaceShade.sv
source/surfaceUnit.sv
testbench/surfaceUnit_chk.sv
testbench/surfaceUnitTb.sv

// File: source/closestHitTracker.sv
`timescale 1ns/1ns

module closestHitTracker import surfacePkg::*; (
    input  logic     clk,
    input  logic     resetn,
    input  logic     rayStart,
    input  ray_t     ray,
    input  rgb8_t    clearColor,
    input  logic     hitValid,
    input  hitData_t hitResult,
    output hitData_t closest,
    output vec3_t    hitPos
);

    logic closer;
    vec3_t travel;

    // Fixed point multiply, product scaled back to the word format
    function automatic fixed_t fixedMul(fixed_t a, fixed_t b);
        logic signed [2*fixedWidth-1:0] product;
        product = a * b;
        return fixed_t'(product >>> fixedFracWidth);
    endfunction

    // Strictly closer, so an equal depth keeps the earlier result
    assign closer = (hitResult.surfaceType != stNone) && (hitResult.t < closest.t);

    // ------------------------------
    // Closest hit register
    // ------------------------------
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            closest <= '0;
            closest.t <= fixedMax;
        end else if (rayStart) begin
            closest.hit <= 1'b0;
            closest.surfaceType <= stNone;
            closest.t <= fixedMax;
            closest.normal <= '0;
            closest.color <= clearColor;
            closest.primIndex <= '0;
        end else if (hitValid && closer) begin
            closest <= hitResult;
        end
    end

    // ------------------------------
    // Hit position along the ray
    // ------------------------------
    assign travel.x = fixedMul(closest.t, ray.dir.x);
    assign travel.y = fixedMul(closest.t, ray.dir.y);
    assign travel.z = fixedMul(closest.t, ray.dir.z);

    assign hitPos.x = ray.orig.x + travel.x;
    assign hitPos.y = ray.orig.y + travel.y;
    assign hitPos.z = ray.orig.z + travel.z;

endmodule

// File: source/primitiveScheduler.sv
`timescale 1ns/1ns

module primitiveScheduler import surfacePkg::*; (
    input  logic          clk,
    input  logic          resetn,
    input  logic          slotFull,
    input  surfaceInput_t slotData,
    input  logic          hitValid,
    input  logic          shadeBusy,
    output logic          take,
    output logic          rayStart,
    output logic          rayDone,
    output surfaceInput_t rayCtx,
    output logic          queryValid,
    output primQuery_t    query
);

    schedState_e state;

    // Group queue, filled once per ray
    primRange_t [groupQueueDepth-1:0] groupQueue;
    primRange_t [groupQueueDepth-1:0] fillList;
    logic [$clog2(groupQueueDepth)-1:0] head;
    logic [$clog2(groupQueueDepth)-1:0] tail;
    logic [$clog2(groupQueueDepth)-1:0] fillCount;

    // Current group being stepped through
    logic [primIndexWidth-1:0] curStart;
    logic [primIndexWidth-1:0] curEnd;
    logic rangeLast;
    logic queueEmpty;
    logic stepNow;

    // End of a group with its count rounded up to whole blocks
    function automatic logic [primIndexWidth-1:0] alignedEnd(primRange_t group);
        logic [primIndexWidth-1:0] rounded;
        rounded = primIndexWidth'(group.count) + primIndexWidth'(testUnitSize - 1);
        rounded = (rounded >> testUnitSizeLog2) << testUnitSizeLog2;
        return group.start + rounded;
    endfunction

    // ------------------------------
    // Queue contents for a new ray
    // ------------------------------
    always_comb begin
        fillList = '0;
        fillList[0].start = primIndexWidth'(globalPrimStart);
        fillList[0].count = primCountWidth'(globalPrimCount);
        fillCount = 1'b1;
        // Empty leaves are skipped so the queue stays packed
        for (int i = 0; i < 2; i++) begin
            if (slotData.leaf[i].count != '0) begin
                fillList[fillCount] = slotData.leaf[i];
                fillCount = fillCount + 1'b1;
            end
        end
    end

    assign take = (state == schIdle) && slotFull;
    assign rayStart = take;
    assign queryValid = (state == schIssue);
    assign rayDone = (state == schDone) && !shadeBusy;

    assign query.startIndex = curStart;
    assign query.endIndex = curStart + primIndexWidth'(testUnitSize);

    assign rangeLast = (query.endIndex == curEnd);
    assign queueEmpty = (head == tail);
    assign stepNow = (state == schWaitHit) && hitValid;

    // ------------------------------
    // FSM and queue pointers
    // ------------------------------
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            state <= schIdle;
            head <= '0;
            tail <= '0;
        end else begin
            case (state)
                schIdle: begin
                    if (take) begin
                        // The global group moves straight into the current range
                        head <= 1'b1;
                        tail <= fillCount;
                        state <= schIssue;
                    end
                end
                schIssue: begin
                    state <= schWaitHit;
                end
                schWaitHit: begin
                    if (hitValid) begin
                        if (!rangeLast) begin
                            state <= schIssue;
                        end else if (!queueEmpty) begin
                            head <= head + 1'b1;
                            state <= schIssue;
                        end else begin
                            state <= schDone;
                        end
                    end
                end
                schDone: begin
                    // Hold here while the shade stage still owns a record
                    if (!shadeBusy) begin
                        state <= schIdle;
                    end
                end
                default: begin
                    state <= schIdle;
                end
            endcase
        end
    end

    // Ray context, queue entries and block position
    always_ff @(posedge clk) begin
        if (take) begin
            rayCtx <= slotData;
            groupQueue <= fillList;
            curStart <= fillList[0].start;
            curEnd <= alignedEnd(fillList[0]);
        end else if (stepNow) begin
            if (!rangeLast) begin
                curStart <= query.endIndex;
            end else if (!queueEmpty) begin
                curStart <= groupQueue[head].start;
                curEnd <= alignedEnd(groupQueue[head]);
            end
        end
    end

endmodule

// File: source/rayIntake.sv
`timescale 1ns/1ns

module rayIntake import surfacePkg::*; (
    input  logic          clk,
    input  logic          resetn,
    input  logic          addInput,
    input  surfaceInput_t inputData,
    input  logic          take,
    output logic          slotFull,
    output surfaceInput_t slotData
);

    logic accept;

    // New rays are only taken into an empty slot
    assign accept = addInput && !slotFull;

    // ------------------------------
    // Slot occupancy
    // ------------------------------
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            slotFull <= 1'b0;
        end else if (take) begin
            slotFull <= 1'b0;
        end else if (accept) begin
            slotFull <= 1'b1;
        end
    end

    // Ray payload, held until the scheduler takes it
    always_ff @(posedge clk) begin
        if (accept) begin
            slotData <= inputData;
        end
    end

endmodule

// File: source/surfacePkg.sv
package surfacePkg;

    // ------------------------------
    // Fixed point format
    // ------------------------------
    localparam int fixedWidth = 32;
    localparam int fixedFracWidth = 16;

    typedef logic signed [fixedWidth-1:0] fixed_t;

    // Largest positive value, used as the starting depth
    localparam fixed_t fixedMax = {1'b0, {(fixedWidth-1){1'b1}}};

    // Position bit that selects the checker square (16 units wide)
    localparam int checkerBit = fixedFracWidth + 4;

    // ------------------------------
    // Primitive indexing
    // ------------------------------
    localparam int primIndexWidth = 16;
    localparam int primCountWidth = 8;
    localparam int testUnitSize = 4;
    localparam int testUnitSizeLog2 = 2;
    localparam int globalPrimStart = 1000;
    localparam int globalPrimCount = 3;
    localparam int groundPrimIndex = 1000;
    localparam int groupQueueDepth = 4;

    typedef enum logic [1:0] {
        stNone,
        stDiffuse,
        stReflective,
        stRefractive
    } surfaceType_e;

    // Scheduler FSM
    typedef enum logic [1:0] {
        schIdle,
        schIssue,
        schWaitHit,
        schDone
    } schedState_e;

    typedef struct packed {
        fixed_t x;
        fixed_t y;
        fixed_t z;
    } vec3_t;

    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgb8_t;

    typedef struct packed {
        vec3_t orig;
        vec3_t dir;
        vec3_t invDir;
        fixed_t minT;
        fixed_t maxT;
        logic [primIndexWidth-1:0] primIndex;
    } ray_t;

    // One group of primitives to be tested against the ray
    typedef struct packed {
        logic [primIndexWidth-1:0] start;
        logic [primCountWidth-1:0] count;
    } primRange_t;

    typedef struct packed {
        logic hit;
        surfaceType_e surfaceType;
        fixed_t t;
        vec3_t normal;
        rgb8_t color;
        logic [primIndexWidth-1:0] primIndex;
    } hitData_t;

    // Block of primitives, end index is exclusive
    typedef struct packed {
        logic [primIndexWidth-1:0] startIndex;
        logic [primIndexWidth-1:0] endIndex;
    } primQuery_t;

    typedef struct packed {
        rgb8_t clearColor;
        vec3_t lightDir;
        vec3_t lightInvDir;
    } renderState_t;

    typedef struct packed {
        logic [15:0] x;
        logic [15:0] y;
        ray_t ray;
        logic [3:0] bounceLevel;
        rgb8_t lastColor;
        primRange_t [1:0] leaf;
    } surfaceInput_t;

    typedef struct packed {
        logic [15:0] x;
        logic [15:0] y;
        rgb8_t lastColor;
        logic [3:0] bounceLevel;
        vec3_t viewDir;
        logic [primIndexWidth-1:0] primIndex;
        vec3_t normal;
        surfaceType_e surfaceType;
        rgb8_t color;
        vec3_t hitPos;
        ray_t shadowRay;
    } surfaceOutput_t;

endpackage

// File: source/surfaceShade.sv
`timescale 1ns/1ns

module surfaceShade import surfacePkg::*; (
    input  logic           clk,
    input  logic           resetn,
    input  logic           rayDone,
    input  surfaceInput_t  rayCtx,
    input  hitData_t       closest,
    input  vec3_t          hitPos,
    input  renderState_t   renderState,
    input  logic           outputFull,
    output logic           shadeBusy,
    output logic           outValid,
    output surfaceOutput_t outData
);

    surfaceOutput_t record;
    logic checkerDark;

    // Odd squares of the ground plane are drawn darker
    assign checkerDark = (closest.surfaceType != stNone)
                      && (closest.primIndex == primIndexWidth'(groundPrimIndex))
                      && (hitPos.x[checkerBit] != hitPos.z[checkerBit]);

    // ------------------------------
    // Output record
    // ------------------------------
    always_comb begin
        record.x = rayCtx.x;
        record.y = rayCtx.y;
        record.lastColor = rayCtx.lastColor;
        record.bounceLevel = rayCtx.bounceLevel;
        record.viewDir = rayCtx.ray.dir;
        record.primIndex = closest.primIndex;
        record.normal = closest.normal;
        record.surfaceType = closest.surfaceType;
        record.hitPos = hitPos;

        record.color = closest.color;
        if (checkerDark) begin
            record.color.r = closest.color.r >> 1;
            record.color.g = closest.color.g >> 1;
            record.color.b = closest.color.b >> 1;
        end

        // Shadow ray from the hit point toward the light
        record.shadowRay.orig = hitPos;
        record.shadowRay.dir = renderState.lightDir;
        record.shadowRay.invDir = renderState.lightInvDir;
        record.shadowRay.minT = '0;
        record.shadowRay.maxT = '1;
        record.shadowRay.primIndex = closest.primIndex;
    end

    // ------------------------------
    // Hand-off under back-pressure
    // ------------------------------
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            shadeBusy <= 1'b0;
            outValid <= 1'b0;
        end else begin
            outValid <= 1'b0;
            if (rayDone) begin
                shadeBusy <= 1'b1;
            end else if (shadeBusy && !outputFull) begin
                outValid <= 1'b1;
                shadeBusy <= 1'b0;
            end
        end
    end

    // Record stays put until the next ray is done
    always_ff @(posedge clk) begin
        if (rayDone) begin
            outData <= record;
        end
    end

endmodule

// File: source/surfaceUnit.sv
`timescale 1ns/1ns

module surfaceUnit import surfacePkg::*; (
    input  logic           clk,
    input  logic           resetn,
    input  logic           addInput,
    input  surfaceInput_t  inputData,
    input  renderState_t   renderState,
    input  logic           outputFull,
    input  logic           hitValid,
    input  hitData_t       hitResult,
    output logic           inputFull,
    output logic           queryValid,
    output primQuery_t     query,
    output logic           outValid,
    output surfaceOutput_t outData
);

    // ------------------------------
    // Stage links
    // ------------------------------
    surfaceInput_t slotData;
    surfaceInput_t rayCtx;
    logic take;
    logic rayStart;
    logic rayDone;
    logic shadeBusy;
    hitData_t closest;
    vec3_t hitPos;

    // Slot level doubles as the input full flag
    rayIntake intake0 (
        .clk      (clk),
        .resetn   (resetn),
        .addInput (addInput),
        .inputData(inputData),
        .take     (take),
        .slotFull (inputFull),
        .slotData (slotData)
    );

    primitiveScheduler sched0 (
        .clk       (clk),
        .resetn    (resetn),
        .slotFull  (inputFull),
        .slotData  (slotData),
        .hitValid  (hitValid),
        .shadeBusy (shadeBusy),
        .take      (take),
        .rayStart  (rayStart),
        .rayDone   (rayDone),
        .rayCtx    (rayCtx),
        .queryValid(queryValid),
        .query     (query)
    );

    closestHitTracker tracker0 (
        .clk       (clk),
        .resetn    (resetn),
        .rayStart  (rayStart),
        .ray       (rayCtx.ray),
        .clearColor(renderState.clearColor),
        .hitValid  (hitValid),
        .hitResult (hitResult),
        .closest   (closest),
        .hitPos    (hitPos)
    );

    surfaceShade shade0 (
        .clk        (clk),
        .resetn     (resetn),
        .rayDone    (rayDone),
        .rayCtx     (rayCtx),
        .closest    (closest),
        .hitPos     (hitPos),
        .renderState(renderState),
        .outputFull (outputFull),
        .shadeBusy  (shadeBusy),
        .outValid   (outValid),
        .outData    (outData)
    );

endmodule

// File: testbench/surfaceUnitTb.sv
`timescale 1ns/1ns

module surfaceUnitTb import surfacePkg::*; ();

    logic clk;
    logic resetn;
    logic addInput;
    surfaceInput_t inputData;
    renderState_t renderState;
    logic outputFull;
    logic hitValid;
    hitData_t hitResult;
    logic inputFull;
    logic queryValid;
    primQuery_t query;
    logic outValid;
    surfaceOutput_t outData;

    // ------------------------------
    // Model state
    // ------------------------------
    surfaceInput_t acceptedRays[$];
    primQuery_t expQueries[$];
    surfaceOutput_t expOutputs[$];
    surfaceInput_t curRay;
    hitData_t bestHit;
    int acceptedCount;
    int outCount;
    int answerWait;
    bit rayActive;
    bit answerPending;
    bit missRay;
    bit finalHit;

    // Expected control levels, advanced once per clock
    bit slotExp;
    bit schedBusy;
    bit schedDone;
    bit shadeExp;
    bit queryValidExp;
    bit outValidExp;

    surfaceUnit dut0 (.*);

    always #10 clk = ~clk;

    task automatic failRun(string reason);
        $display("%s", reason);
        $display("sim failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic checkLevel(string name, logic got, logic exp);
        if (got !== exp) begin
            failRun($sformatf("error %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic checkQuery(primQuery_t got, primQuery_t exp);
        if (got !== exp) begin
            failRun($sformatf("error query got %h expected %h", got, exp));
        end
    endtask

    task automatic checkOutput(surfaceOutput_t got, surfaceOutput_t exp);
        if (got !== exp) begin
            failRun($sformatf("error outData got %h expected %h", got, exp));
        end
    endtask

    function automatic fixed_t randomFixed(int lo, int hi);
        return fixed_t'(lo + int'($urandom_range(0, hi - lo)));
    endfunction

    function automatic vec3_t randomVec(int lo, int hi);
        vec3_t v;
        v.x = randomFixed(lo, hi);
        v.y = randomFixed(lo, hi);
        v.z = randomFixed(lo, hi);
        return v;
    endfunction

    function automatic surfaceInput_t randomInput();
        surfaceInput_t in;
        in.x = 16'($urandom);
        in.y = 16'($urandom);
        in.ray.orig = randomVec(-100 << 16, 100 << 16);
        in.ray.dir = randomVec(-65536, 65536);
        in.ray.invDir = randomVec(-(1 << 24), 1 << 24);
        in.ray.minT = randomFixed(0, 65536);
        in.ray.maxT = randomFixed(65536, 1 << 28);
        in.ray.primIndex = 16'($urandom);
        in.bounceLevel = 4'($urandom);
        in.lastColor = 24'($urandom);
        // Empty leaves and partial blocks both show up
        for (int i = 0; i < 2; i++) begin
            in.leaf[i].start = 16'($urandom_range(0, 40000));
            in.leaf[i].count = ($urandom_range(0, 3) == 0) ? 8'd0 : 8'($urandom_range(1, 11));
        end
        return in;
    endfunction

    function automatic hitData_t randomHit();
        hitData_t h;
        h.surfaceType = missRay ? stNone : surfaceType_e'($urandom_range(0, 3));
        h.hit = (h.surfaceType != stNone);
        h.t = randomFixed(1 << 16, 200 << 16);
        // Reuse the current depth now and then for the tie case
        if (bestHit.surfaceType != stNone && $urandom_range(0, 3) == 0) begin
            h.t = bestHit.t;
        end
        h.normal = randomVec(-65536, 65536);
        h.color = 24'($urandom);
        h.primIndex = ($urandom_range(0, 1) == 0) ? 16'(groundPrimIndex) : 16'($urandom);
        return h;
    endfunction

    function automatic fixed_t alongRay(fixed_t t, fixed_t d);
        longint p;
        p = longint'(t) * longint'(d);
        return fixed_t'(p >>> fixedFracWidth);
    endfunction

    function automatic surfaceOutput_t expectedOutput(surfaceInput_t in, hitData_t best);
        surfaceOutput_t o;
        vec3_t pos;
        pos.x = in.ray.orig.x + alongRay(best.t, in.ray.dir.x);
        pos.y = in.ray.orig.y + alongRay(best.t, in.ray.dir.y);
        pos.z = in.ray.orig.z + alongRay(best.t, in.ray.dir.z);
        o.x = in.x;
        o.y = in.y;
        o.lastColor = in.lastColor;
        o.bounceLevel = in.bounceLevel;
        o.viewDir = in.ray.dir;
        o.primIndex = best.primIndex;
        o.normal = best.normal;
        o.surfaceType = best.surfaceType;
        o.color = best.color;
        // Dark checker squares on the ground
        if (best.surfaceType != stNone && best.primIndex == groundPrimIndex
                && pos.x[checkerBit] != pos.z[checkerBit]) begin
            o.color.r = best.color.r >> 1;
            o.color.g = best.color.g >> 1;
            o.color.b = best.color.b >> 1;
        end
        o.hitPos = pos;
        o.shadowRay.orig = pos;
        o.shadowRay.dir = renderState.lightDir;
        o.shadowRay.invDir = renderState.lightInvDir;
        o.shadowRay.minT = '0;
        o.shadowRay.maxT = '1;
        o.shadowRay.primIndex = best.primIndex;
        return o;
    endfunction

    // Whole blocks covering one group, count rounded up
    task automatic addGroup(int start, int count);
        primQuery_t q;
        for (int b = 0; b < (count + testUnitSize - 1) / testUnitSize; b++) begin
            q.startIndex = 16'(start + b * testUnitSize);
            q.endIndex = 16'(start + (b + 1) * testUnitSize);
            expQueries.push_back(q);
        end
    endtask

    task automatic takeQuery();
        if (answerPending) begin
            failRun("a query was issued before the previous one was answered");
        end else if (!rayActive && acceptedRays.size() == 0) begin
            failRun("a query was issued with no accepted ray");
        end else begin
            if (!rayActive) begin
                curRay = acceptedRays.pop_front();
                addGroup(globalPrimStart, globalPrimCount);
                for (int i = 0; i < 2; i++) begin
                    if (curRay.leaf[i].count != 0) begin
                        addGroup(curRay.leaf[i].start, curRay.leaf[i].count);
                    end
                end
                bestHit = '0;
                bestHit.surfaceType = stNone;
                bestHit.t = fixedMax;
                bestHit.color = renderState.clearColor;
                missRay = ($urandom_range(0, 3) == 0);
                rayActive = 1'b1;
            end
            checkQuery(query, expQueries.pop_front());
            answerPending = 1'b1;
            answerWait = $urandom_range(1, 4);
        end
    endtask

    task automatic sendAnswer();
        hitData_t h;
        h = randomHit();
        hitResult <= h;
        hitValid <= 1'b1;
        // Only a strictly nearer hit replaces the stored one
        if (h.surfaceType != stNone && h.t < bestHit.t) begin
            bestHit = h;
        end
        answerPending = 1'b0;
        if (expQueries.size() == 0) begin
            expOutputs.push_back(expectedOutput(curRay, bestHit));
            rayActive = 1'b0;
            finalHit <= 1'b1;
        end
    endtask

    // ------------------------------
    // Intersection responder and output monitor
    // ------------------------------
    always @(posedge clk) begin
        outputFull <= resetn && ($urandom_range(0, 2) == 0);
        hitValid <= 1'b0;
        finalHit <= 1'b0;
        if (resetn && queryValid) begin
            takeQuery();
        end
        if (resetn && answerPending) begin
            answerWait--;
            if (answerWait == 0) begin
                sendAnswer();
            end
        end
        if (resetn && outValid) begin
            if (expOutputs.size() == 0) begin
                failRun("an output appeared with no finished ray pending");
            end else begin
                checkOutput(outData, expOutputs.pop_front());
                outCount++;
            end
        end
    end

    // ------------------------------
    // Slot, scheduler and shade hand-off
    // ------------------------------
    always @(posedge clk) begin
        bit takeExp;
        bit doneExp;
        if (!resetn) begin
            slotExp <= 1'b0;
            schedBusy <= 1'b0;
            schedDone <= 1'b0;
            shadeExp <= 1'b0;
            queryValidExp <= 1'b0;
            outValidExp <= 1'b0;
        end else begin
            if (dut0.chk0.assertFailed) begin
                failRun("an assertion in the bound checker failed");
            end
            checkLevel("inputFull", inputFull, slotExp);
            checkLevel("queryValid", queryValid, queryValidExp);
            checkLevel("outValid", outValid, outValidExp);
            takeExp = !schedBusy && !schedDone && slotExp;
            doneExp = schedDone && !shadeExp;
            // Slot fills from an idle input and empties when a ray starts
            if (takeExp) begin
                slotExp <= 1'b0;
            end else if (addInput && !slotExp) begin
                slotExp <= 1'b1;
            end
            queryValidExp <= takeExp || (hitValid && !finalHit);
            if (takeExp) begin
                schedBusy <= 1'b1;
            end else if (hitValid && finalHit) begin
                schedBusy <= 1'b0;
                schedDone <= 1'b1;
            end else if (doneExp) begin
                schedDone <= 1'b0;
            end
            outValidExp <= shadeExp && !outputFull;
            if (doneExp) begin
                shadeExp <= 1'b1;
            end else if (!outputFull) begin
                shadeExp <= 1'b0;
            end
        end
    end

    task automatic feedRays(int rays, int limit);
        int cycles;
        cycles = 0;
        while (acceptedCount < rays) begin
            @(posedge clk);
            if (addInput && !slotExp) begin
                acceptedRays.push_back(inputData);
                acceptedCount++;
            end
            // Attempts against a full slot are made too
            addInput <= (acceptedCount < rays) && ($urandom_range(0, 2) == 0);
            inputData <= randomInput();
            cycles++;
            if (cycles > limit) begin
                failRun("timed out while feeding rays into the DUT");
            end
        end
    endtask

    task automatic waitForOutputs(int limit);
        int cycles;
        cycles = 0;
        while (outCount < acceptedCount) begin
            @(posedge clk);
            cycles++;
            if (cycles > limit) begin
                failRun("timed out waiting for the DUT outputs");
            end
        end
    endtask

    initial begin
        void'($urandom(32'hac9593f8));
        clk = 1'b0;
        resetn = 1'b0;
        addInput = 1'b0;
        inputData = '0;
        outputFull = 1'b0;
        hitValid = 1'b0;
        hitResult = '0;
        renderState.clearColor = 24'($urandom);
        renderState.lightDir = randomVec(-65536, 65536);
        renderState.lightInvDir = randomVec(-(1 << 24), 1 << 24);
        acceptedCount = 0;
        outCount = 0;
        answerWait = 0;
        rayActive = 1'b0;
        answerPending = 1'b0;
        missRay = 1'b0;
        finalHit = 1'b0;
        bestHit = '0;
        repeat (2) @(posedge clk);
        resetn <= 1'b1;
        feedRays(60, 20000);
        waitForOutputs(20000);
        // Quiet stretch to catch any extra output
        repeat (20) @(posedge clk);
        if (outCount == acceptedCount && expOutputs.size() == 0 && !rayActive) begin
            $display("sim passed");
            $finish;
        end else begin
            failRun("the number of outputs does not match the accepted rays");
        end
    end

endmodule

// File: testbench/surfaceUnit_chk.sv
`timescale 1ns/1ns

module surfaceUnit_chk (
    input logic clk,
    input logic resetn,
    input logic outputFull,
    input logic outValid,
    input logic queryValid,
    input logic inputFull
);

    // Set once any assertion below has fired
    logic assertFailed;

    initial assertFailed = 1'b0;

    // Back-pressure blocks the next output
    assert property (@(posedge clk) disable iff (!resetn) outputFull |=> !outValid)
        else begin
            assertFailed = 1'b1;
            $error("outValid followed a cycle with outputFull high");
        end

    // One query at a time
    assert property (@(posedge clk) disable iff (!resetn) queryValid |=> !queryValid)
        else begin
            assertFailed = 1'b1;
            $error("queryValid was high in two consecutive cycles");
        end

    assert property (@(posedge clk) $rose(resetn) |-> !inputFull && !outValid)
        else begin
            assertFailed = 1'b1;
            $error("inputFull or outValid high right after reset");
        end

endmodule

bind surfaceUnit surfaceUnit_chk chk0 (
    .clk       (clk),
    .resetn    (resetn),
    .outputFull(outputFull),
    .outValid  (outValid),
    .queryValid(queryValid),
    .inputFull (inputFull)
);
